//--- project.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/operand_decode.sv
logic/operand_muxes.sv
logic/exec_stage.sv
logic/alu_pipe_top.sv
test/tb_clock_gen.sv
test/alu_pipe_tb.sv

//--- test/alu_pipe_tb.sv
`timescale 1ns/10ps

module alu_pipe_tb;
	import isa_pkg::*;

	// Instruction counts that size the watchdog
	localparam int N_FIXED   = 70;
	localparam int N_RAND    = 60;
	localparam int MAX_FRZ   = 4;
	localparam int RUN_LIMIT = 2 * (N_FIXED + N_RAND + N_RAND * MAX_FRZ) + 200;

	logic     clk, rst_n;
	logic     id_valid, id_use_imm, id_freeze, ex_freeze, retire_valid;
	reg_idx_t id_rd, id_ra, id_rb, retire_rd;
	word_t    id_imm, retire_data;
	alu_op_e  id_op;

	// Architectural state in program order
	word_t    model [NUM_REGS];
	// Expected retires with the oldest at the front
	reg_idx_t exp_rd_q [$];
	word_t    exp_data_q [$];
	int       errors, checks, cycles;

	tb_clock_gen #(.PERIOD(20)) clock_inst (.clk(clk));

	alu_pipe_top #(.WIDTH(32)) alu_pipe_top_inst (
		.clk(clk), .rst_n(rst_n),
		.id_valid(id_valid), .id_rd(id_rd), .id_ra(id_ra), .id_rb(id_rb),
		.id_imm(id_imm), .id_use_imm(id_use_imm), .id_op(id_op),
		.id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
	);

	////////////////////
	// Reference model
	////////////////////

	// Immediate replaces B
	// Shift amount is the low five bits of B
	function automatic word_t expect_result(input alu_op_e op, input word_t a, input word_t b,
		input word_t imm, input logic use_imm);
		word_t bv;

		bv = use_imm ? imm : b;
		case (op)
			ALU_ADD: return a + bv;
			ALU_SUB: return a - bv;
			ALU_AND: return a & bv;
			ALU_OR:  return a | bv;
			ALU_XOR: return a ^ bv;
			ALU_SLL: return a << bv[4:0];
			ALU_SRL: return a >> bv[4:0];
			default: return bv;
		endcase
	endfunction

	////////////////////
	// Stimulus tasks
	////////////////////

	// Called at a falling edge
	// Holds the instruction through frz frozen cycles and one accepting cycle
	// ex_freeze covers cycles ex_from to ex_from+ex_len-1 of the run
	task automatic issue_instr(input alu_op_e op, input reg_idx_t rd, input reg_idx_t ra,
		input reg_idx_t rb, input word_t imm, input logic use_imm,
		input int frz, input int ex_from, input int ex_len);
		word_t res;

		res = expect_result(op, model[ra], model[rb], imm, use_imm);
		// r0 retires its result but keeps zero
		if (rd != '0)
			model[rd] = res;
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(res);
		id_valid   = 1'b1;
		id_op      = op;
		id_rd      = rd;
		id_ra      = ra;
		id_rb      = rb;
		id_imm     = imm;
		id_use_imm = use_imm;
		for (int i = 0; i < frz; i++) begin
			id_freeze = 1'b1;
			ex_freeze = (i >= ex_from) && (i < ex_from + ex_len);
			@(negedge clk);
		end
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		@(negedge clk);
		id_valid = 1'b0;
	endtask

	task automatic issue_plain(input alu_op_e op, input reg_idx_t rd, input reg_idx_t ra,
		input reg_idx_t rb, input word_t imm, input logic use_imm);
		issue_instr(op, rd, ra, rb, imm, use_imm, 0, 0, 0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Waits for the pipeline to drain and reports the test
	task automatic finish_test(input string name, input int err_base);
		int n;

		n = 0;
		while (exp_rd_q.size() > 0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (exp_rd_q.size() > 0) begin
			$display("Test %s: %0d instructions never retired", name, exp_rd_q.size());
			errors += exp_rd_q.size();
			exp_rd_q.delete();
			exp_data_q.delete();
		end
		$display("Test %s finished with %0d errors", name, errors - err_base);
	endtask

	function automatic alu_op_e rand_op();
		return alu_op_e'($urandom_range(7, 0));
	endfunction

	////////////////////
	// Compare and watchdog
	////////////////////

	// Each retire pulse pops the oldest expected entry
	always @(posedge clk) begin
		if (rst_n && retire_valid) begin
			if (ex_freeze) begin
				$display("Retire pulse during ex_freeze at %0t", $time);
				errors++;
			end
			if (exp_rd_q.size() == 0) begin
				$display("Extra retire pulse at %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				checks++;
				if (retire_rd !== exp_rd_q[0] || retire_data !== exp_data_q[0]) begin
					$display("ERROR %0t: retire rd %0d data %h, expected rd %0d data %h",
						$time, retire_rd, retire_data, exp_rd_q[0], exp_data_q[0]);
					errors++;
				end
				void'(exp_rd_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > RUN_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int       base;
		int       frz, ex_from, ex_len;
		reg_idx_t prev;

		void'($urandom(36308));
		rst_n      = 1'b0;
		id_valid   = 1'b0;
		id_op      = ALU_ADD;
		id_rd      = '0;
		id_ra      = '0;
		id_rb      = '0;
		id_imm     = '0;
		id_use_imm = 1'b0;
		id_freeze  = 1'b0;
		ex_freeze  = 1'b0;
		errors     = 0;
		checks     = 0;
		cycles     = 0;
		for (int i = 0; i < NUM_REGS; i++)
			model[i] = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Load r1 and r2 and let them reach the RF
		// Every op then reads them from the RF
		base = errors;
		for (int rep = 0; rep < 2; rep++) begin
			issue_plain(ALU_PASS_B, 5'd1, 5'd0, 5'd0, $urandom(), 1'b1);
			issue_plain(ALU_PASS_B, 5'd2, 5'd0, 5'd0, $urandom(), 1'b1);
			idle_cycles(3);
			for (int k = 0; k < 8; k++)
				issue_plain(alu_op_e'(k), reg_idx_t'(8 + k), 5'd1, 5'd2, '0, 1'b0);
		end
		finish_test("1 register file operands", base);

		// Chain where each result feeds the next
		// Even steps take it on A and odd steps on B
		// ADD, SUB, AND, OR and XOR use both operands in full
		base = errors;
		prev = 5'd15;
		for (int k = 0; k < 8; k++) begin
			if (k % 2 == 0)
				issue_plain(alu_op_e'(k % 5), reg_idx_t'(16 + k), prev, 5'd2, '0, 1'b0);
			else
				issue_plain(alu_op_e'(k % 5), reg_idx_t'(16 + k), 5'd1, prev, '0, 1'b0);
			prev = reg_idx_t'(16 + k);
		end
		finish_test("2 EX forwarding", base);

		// Dependency two apart
		// ADD of a register with itself still shows a stale value
		base = errors;
		for (int k = 0; k < 4; k++) begin
			issue_plain(rand_op(), 5'd20, 5'd1, 5'd2, '0, 1'b0);
			issue_plain(rand_op(), 5'd21, 5'd2, 5'd1, '0, 1'b0);
			issue_plain(ALU_ADD, 5'd22, 5'd20, 5'd20, '0, 1'b0);
		end
		// Same register in both EX and WB
		for (int k = 0; k < 4; k++) begin
			issue_plain(ALU_PASS_B, 5'd23, 5'd0, 5'd0, $urandom(), 1'b1);
			issue_plain(ALU_PASS_B, 5'd23, 5'd0, 5'd0, $urandom(), 1'b1);
			issue_plain(ALU_ADD, 5'd24, 5'd23, 5'd1, '0, 1'b0);
		end
		finish_test("3 WB forwarding", base);

		// Write to r0 is dropped
		// Immediate wins over a WB match on rb
		base = errors;
		for (int k = 0; k < 6; k++) begin
			issue_plain(rand_op(), 5'd0, 5'd1, 5'd2, '0, 1'b0);
			issue_plain(rand_op(), 5'd25, 5'd0, 5'd26, $urandom(), 1'b1);
			issue_plain(rand_op(), 5'd26, 5'd25, 5'd0, '0, 1'b0);
		end
		finish_test("4 immediate and r0", base);

		// Dependent stream on a few registers under random freeze runs
		base = errors;
		for (int k = 0; k < N_RAND; k++) begin
			frz     = 0;
			ex_from = 0;
			ex_len  = 0;
			if ($urandom_range(2, 0) == 0) begin
				frz     = $urandom_range(MAX_FRZ, 1);
				ex_from = $urandom_range(frz - 1, 0);
				ex_len  = $urandom_range(frz - ex_from, 0);
			end
			issue_instr(rand_op(), reg_idx_t'($urandom_range(19, 16)),
				reg_idx_t'($urandom_range(19, 15)), reg_idx_t'($urandom_range(19, 15)),
				$urandom(), ($urandom_range(3, 0) == 0), frz, ex_from, ex_len);
		end
		finish_test("5 random freezes", base);

		$display("Summary: %0d retires checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	// Free-running clock, starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

//--- logic/alu_pipe_top.sv
`timescale 1ns/10ps

module alu_pipe_top #(
	parameter int WIDTH = $bits(isa_pkg::word_t)
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              id_valid,
	input  isa_pkg::reg_idx_t id_rd,
	input  isa_pkg::reg_idx_t id_ra,
	input  isa_pkg::reg_idx_t id_rb,
	input  logic [WIDTH-1:0]  id_imm,
	input  logic              id_use_imm,
	input  isa_pkg::alu_op_e  id_op,
	input  logic              id_freeze,
	input  logic              ex_freeze,
	output logic              retire_valid,
	output isa_pkg::reg_idx_t retire_rd,
	output logic [WIDTH-1:0]  retire_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [WIDTH-1:0] rf_dataa, rf_datab;
	logic [WIDTH-1:0] ex_forw, wb_forw;
	logic [WIDTH-1:0] operand_a, operand_b;
	sel_t             sel_a, sel_b;
	reg_idx_t         ex_rd, wb_rd, rf_waddr;
	logic             ex_wr, wb_wr, rf_we;

	////////////////////
	// Decode stage
	////////////////////

	reg_file #(.WIDTH(WIDTH)) reg_file_inst (
		.clk(clk), .rst_n(rst_n),
		.raddr_a(id_ra), .raddr_b(id_rb),
		.we(rf_we), .waddr(rf_waddr), .wdata(wb_forw),
		.rdata_a(rf_dataa), .rdata_b(rf_datab)
	);

	operand_decode operand_decode_inst (
		.id_ra(id_ra), .id_rb(id_rb), .id_use_imm(id_use_imm),
		.ex_rd(ex_rd), .ex_wr(ex_wr), .wb_rd(wb_rd), .wb_wr(wb_wr),
		.sel_a(sel_a), .sel_b(sel_b)
	);

	////////////////////
	// Operand and execute stages
	////////////////////

	// Muxed values stay internal, probed by the testbench if needed
	operand_muxes #(.WIDTH(WIDTH)) operand_muxes_inst (
		.clk(clk), .rst_n(rst_n), .id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.rf_dataa(rf_dataa), .rf_datab(rf_datab),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .simm(id_imm),
		.sel_a(sel_a), .sel_b(sel_b),
		.operand_a(operand_a), .operand_b(operand_b),
		.muxed_a(), .muxed_b()
	);

	exec_stage #(.WIDTH(WIDTH)) exec_stage_inst (
		.clk(clk), .rst_n(rst_n), .id_freeze(id_freeze), .ex_freeze(ex_freeze),
		.id_valid(id_valid), .id_rd(id_rd), .id_op(id_op),
		.operand_a(operand_a), .operand_b(operand_b),
		.ex_forw(ex_forw), .wb_forw(wb_forw),
		.ex_rd(ex_rd), .wb_rd(wb_rd), .ex_wr(ex_wr), .wb_wr(wb_wr),
		.rf_we(rf_we), .rf_waddr(rf_waddr),
		.retire_valid(retire_valid), .retire_rd(retire_rd)
	);

	// Retired value is the WB register
	assign retire_data = wb_forw;

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/10ps

module exec_stage #(
	parameter int WIDTH = $bits(isa_pkg::word_t)
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              id_freeze,
	input  logic              ex_freeze,
	input  logic              id_valid,
	input  isa_pkg::reg_idx_t id_rd,
	input  isa_pkg::alu_op_e  id_op,
	input  logic [WIDTH-1:0]  operand_a,
	input  logic [WIDTH-1:0]  operand_b,
	output logic [WIDTH-1:0]  ex_forw,
	output logic [WIDTH-1:0]  wb_forw,
	output isa_pkg::reg_idx_t ex_rd,
	output isa_pkg::reg_idx_t wb_rd,
	output logic              ex_wr,
	output logic              wb_wr,
	output logic              rf_we,
	output isa_pkg::reg_idx_t rf_waddr,
	output logic              retire_valid,
	output isa_pkg::reg_idx_t retire_rd
);
	import isa_pkg::*;

	localparam int SHAMT_W = $clog2(WIDTH);

	logic               ex_valid;
	alu_op_e            ex_op;
	logic               wb_valid;
	logic [SHAMT_W-1:0] shamt;

	////////////////////
	// EX control
	////////////////////

	// Same edges as the operand registers
	// id_freeze alone sends a bubble, ex_freeze holds the stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_rd    <= '0;
			ex_op    <= ALU_ADD;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				ex_valid <= 1'b0;
			end else begin
				ex_valid <= id_valid;
				ex_rd    <= id_rd;
				ex_op    <= id_op;
			end
		end
	end

	////////////////////
	// ALU
	////////////////////

	assign shamt = operand_b[SHAMT_W-1:0];

	always_comb begin
		case (ex_op)
			ALU_ADD: ex_forw = operand_a + operand_b;
			ALU_SUB: ex_forw = operand_a - operand_b;
			ALU_AND: ex_forw = operand_a & operand_b;
			ALU_OR:  ex_forw = operand_a | operand_b;
			ALU_XOR: ex_forw = operand_a ^ operand_b;
			ALU_SLL: ex_forw = operand_a << shamt;
			ALU_SRL: ex_forw = operand_a >> shamt;
			// Pass-b
			default: ex_forw = operand_b;
		endcase
	end

	////////////////////
	// WB register and retire
	////////////////////

	// Advances with EX, holds under back-pressure
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_forw  <= '0;
		end else if (!ex_freeze) begin
			wb_valid <= ex_valid;
			wb_rd    <= ex_rd;
			wb_forw  <= ex_forw;
		end
	end

	// Only a valid result with a real destination forwards or writes
	assign ex_wr = ex_valid && (ex_rd != '0);
	assign wb_wr = wb_valid && (wb_rd != '0);

	// RF write and retire share the edge where WB moves on
	assign rf_we        = wb_wr && !ex_freeze;
	assign rf_waddr     = wb_rd;
	assign retire_valid = wb_valid && !ex_freeze;
	assign retire_rd    = wb_rd;

	////////////////////
	// Assertions
	////////////////////

	// Pipeline control freezes EX only together with ID
	a_freeze_order: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |-> id_freeze);

	// A frozen WB entry does not retire yet and is still there next cycle
	a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_valid && ex_freeze) |-> !retire_valid ##1
		(wb_valid && $stable(wb_rd) && $stable(wb_forw)));

endmodule

//--- logic/operand_muxes.sv
`timescale 1ns/10ps

module operand_muxes #(
	parameter int WIDTH = $bits(isa_pkg::word_t)
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             id_freeze,
	input  logic             ex_freeze,
	input  logic [WIDTH-1:0] rf_dataa,
	input  logic [WIDTH-1:0] rf_datab,
	input  logic [WIDTH-1:0] ex_forw,
	input  logic [WIDTH-1:0] wb_forw,
	input  logic [WIDTH-1:0] simm,
	input  pipe_pkg::sel_t   sel_a,
	input  pipe_pkg::sel_t   sel_b,
	output logic [WIDTH-1:0] operand_a,
	output logic [WIDTH-1:0] operand_b,
	output logic [WIDTH-1:0] muxed_a,
	output logic [WIDTH-1:0] muxed_b
);
	import pipe_pkg::*;

	// Index 0 is operand A, index 1 is operand B
	logic [WIDTH-1:0] muxed [2];
	logic [WIDTH-1:0] op_q  [2];
	logic             saved [2];

	////////////////////
	// Forwarding muxes
	////////////////////

	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			default:     muxed_a = rf_dataa;
		endcase

		case (sel_b)
			SEL_IMM:     muxed_b = simm;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = rf_datab;
		endcase
	end

	assign muxed[0] = muxed_a;
	assign muxed[1] = muxed_b;

	////////////////////
	// Operand registers
	////////////////////

	// Load on every edge without ex_freeze
	// First id_freeze edge captures the held ID operand and sets saved
	// Register then holds until the instruction is accepted
	// saved follows id_freeze, so it drops on the accepting edge
	for (genvar i = 0; i < 2; i++) begin : g_op_reg
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				op_q[i]  <= '0;
				saved[i] <= 1'b0;
			end else if (!ex_freeze) begin
				if (!saved[i])
					op_q[i] <= muxed[i];
				saved[i] <= id_freeze;
			end
		end
	end

	assign operand_a = op_q[0];
	assign operand_b = op_q[1];

	////////////////////
	// Assertions
	////////////////////

	// A loading register takes the source that decode named one edge earlier
	property p_load_src(sel_t sel, logic sv, logic [WIDTH-1:0] op,
		logic [WIDTH-1:0] rf, logic [WIDTH-1:0] imm);
		@(posedge clk) disable iff (!rst_n)
		(!ex_freeze && !sv) |=> op == $past(
			(sel == SEL_EX_FORW) ? ex_forw :
			(sel == SEL_WB_FORW) ? wb_forw :
			(sel == SEL_IMM)     ? imm     : rf);
	endproperty

	// A has no immediate leg, so the RF word stands in for it
	a_load_src: assert property (p_load_src(sel_a, saved[0], operand_a, rf_dataa, rf_dataa));
	b_load_src: assert property (p_load_src(sel_b, saved[1], operand_b, rf_datab, simm));

	// Accepting edge leaves no saved operand behind
	a_saved_clear: assert property (@(posedge clk) disable iff (!rst_n)
		(!ex_freeze && !id_freeze) |=> (!saved[0] && !saved[1]));

endmodule

//--- logic/operand_decode.sv
`timescale 1ns/10ps

module operand_decode (
	input  isa_pkg::reg_idx_t id_ra,
	input  isa_pkg::reg_idx_t id_rb,
	input  logic              id_use_imm,
	input  isa_pkg::reg_idx_t ex_rd,
	input  logic              ex_wr,
	input  isa_pkg::reg_idx_t wb_rd,
	input  logic              wb_wr,
	output pipe_pkg::sel_t    sel_a,
	output pipe_pkg::sel_t    sel_b
);
	import isa_pkg::*;
	import pipe_pkg::*;

	////////////////////
	// Forwarding source
	////////////////////

	// Picks the newest producer of one source register
	// EX is younger than WB so it is tested first
	// r0 is constant and never forwards
	function automatic sel_t fwd_sel(
		input reg_idx_t src,
		input reg_idx_t ex_dst,
		input logic     ex_ok,
		input reg_idx_t wb_dst,
		input logic     wb_ok
	);
		sel_t sel;

		sel = SEL_RF;
		if (src != '0) begin
			if (ex_ok && src == ex_dst)
				sel = SEL_EX_FORW;
			else if (wb_ok && src == wb_dst)
				sel = SEL_WB_FORW;
		end
		return sel;
	endfunction

	////////////////////
	// Select outputs
	////////////////////

	// Operand A has no immediate leg
	// Operand B takes the immediate ahead of any forwarding
	always_comb begin
		sel_a = fwd_sel(id_ra, ex_rd, ex_wr, wb_rd, wb_wr);

		if (id_use_imm)
			sel_b = SEL_IMM;
		else
			sel_b = fwd_sel(id_rb, ex_rd, ex_wr, wb_rd, wb_wr);
	end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file #(
	parameter int WIDTH = $bits(isa_pkg::word_t)
) (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::reg_idx_t raddr_a,
	input  isa_pkg::reg_idx_t raddr_b,
	input  logic              we,
	input  isa_pkg::reg_idx_t waddr,
	input  logic [WIDTH-1:0]  wdata,
	output logic [WIDTH-1:0]  rdata_a,
	output logic [WIDTH-1:0]  rdata_b
);
	import isa_pkg::*;

	// Flop array, one word per architectural register
	logic [WIDTH-1:0] regs [NUM_REGS];

	////////////////////
	// Write port
	////////////////////

	// Whole array clears on reset
	// r0 is never written so it stays zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Combinational, same cycle as the index
	// A write lands at the edge, WB forwarding covers the cycle before
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

	////////////////////
	// Operand select codes
	////////////////////

	// Width of a select, shared by decode and the operand muxes
	localparam int SEL_WIDTH = 2;

	typedef logic [SEL_WIDTH-1:0] sel_t;

	// Register file read data
	localparam sel_t SEL_RF      = 2'd0;
	// Immediate, operand B only
	localparam sel_t SEL_IMM     = 2'd1;
	// ALU result of the instruction in EX
	localparam sel_t SEL_EX_FORW = 2'd2;
	// Result held in the WB register
	localparam sel_t SEL_WB_FORW = 2'd3;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

	////////////////////
	// Data types of the integer ISA
	////////////////////

	// Operand and result word of the base machine
	typedef logic [31:0] word_t;

	// Architectural register index
	typedef logic [4:0] reg_idx_t;

	// Register count, r0 reads as zero
	localparam int NUM_REGS = 32;

	// ALU operation, decoded ahead of this slice
	// Shifts take the amount from the low bits of operand B
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_SLL    = 3'd5,
		ALU_SRL    = 3'd6,
		ALU_PASS_B = 3'd7
	} alu_op_e;

endpackage
